//--- design/keypadPkg.sv
//////////////////////////////////////////////////////////////////////
// keypad definitions
// geometry of the 4x4 hex keypad, the row and column line types,
// the key code and the scanner state encoding
//////////////////////////////////////////////////////////////////////

`default_nettype none

package keypadPkg;

    // keypad geometry
    localparam int numRows = 4;
    localparam int numCols = 4;

    // one-hot row drive, bit n drives row n
    typedef logic [numRows-1:0] rowLines_t;

    // column sense lines, high while a key in the driven row is closed
    typedef logic [numCols-1:0] colLines_t;

    // hex value of a key
    typedef logic [3:0] keyCode_t;

    // scanner state
    // scanning walks the rows, holding keeps the pressed key's row driven
    typedef enum logic {
        scanning,
        holding
    } scanState_t;

endpackage

`default_nettype wire

//--- design/displayPkg.sv
//////////////////////////////////////////////////////////////////////
// display definitions
// digit and segment types for the two-digit seven-segment display
//////////////////////////////////////////////////////////////////////

`default_nettype none

package displayPkg;

    // digits on the display, left and right
    localparam int numDigits = 2;

    // one displayed hex digit
    typedef logic [3:0] digit_t;

    // segment lines, active low
    // bit 0 is segment a, bit 6 is segment g
    typedef logic [6:0] segments_t;

endpackage

`default_nettype wire

//--- design/keypadScanner.sv
//////////////////////////////////////////////////////////////////////
// keypad scanner
// drives the keypad rows one at a time, reads the columns through a
// two-flop synchronizer and decodes a closed key into its hex code.
// a found key keeps its row driven until its column drops.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module keypadScanner
    import keypadPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  colLines_t col,
    output rowLines_t row,
    output logic      keyValid,
    output keyCode_t  keyCode
);

    localparam int rowBits    = $clog2(numRows);
    localparam int colBits    = $clog2(numCols);
    localparam int syncDepth  = 2;
    localparam int settleBits = $clog2(syncDepth + 1);

    // key at each row and column of the pad
    localparam keyCode_t keyMap [numRows][numCols] = '{
        '{4'hA, 4'h0, 4'hB, 4'hF},
        '{4'h7, 4'h8, 4'h9, 4'hE},
        '{4'h4, 4'h5, 4'h6, 4'hD},
        '{4'h1, 4'h2, 4'h3, 4'hC}
    };

    colLines_t              colMeta;
    colLines_t              colSync;
    scanState_t             state;
    logic [rowBits-1:0]     rowIdx;
    logic [rowBits-1:0]     heldRow;
    logic [colBits-1:0]     heldCol;
    logic [settleBits-1:0]  settle;
    logic [rowBits-1:0]     hitRow;
    logic [colBits-1:0]     hitCol;
    logic                   hit;
    logic                   released;

    // two-flop column synchronizer
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            colMeta <= '0;
            colSync <= '0;
        end else begin
            colMeta <= col;
            colSync <= colMeta;
        end
    end

    // synchronized columns belong to the row driven syncDepth cycles ago
    assign hitRow = rowIdx - rowBits'(syncDepth);

    // lowest set column wins
    always_comb begin
        hitCol = '0;
        for (int c = numCols - 1; c >= 0; c--) begin
            if (colSync[c]) begin
                hitCol = colBits'(c);
            end
        end
    end

    // after a state change the synchronizer still carries the old row,
    // so decisions wait until it has flushed
    assign hit      = (colSync != '0) && (settle == '0);
    assign released = !colSync[heldCol] && (settle == '0);

    assign row = rowLines_t'(1) << ((state == holding) ? heldRow : rowIdx);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= scanning;
            rowIdx   <= '0;
            heldRow  <= '0;
            heldCol  <= '0;
            settle   <= '0;
            keyValid <= 1'b0;
        end else begin
            if (settle != '0) begin
                settle <= settle - 1'b1;
            end
            case (state)
                scanning: begin
                    if (hit) begin
                        state    <= holding;
                        heldRow  <= hitRow;
                        heldCol  <= hitCol;
                        settle   <= settleBits'(syncDepth);
                        keyValid <= 1'b1;
                    end else begin
                        rowIdx <= rowIdx + 1'b1;
                    end
                end
                holding: begin
                    if (released) begin
                        // resume on the row after the released key
                        state    <= scanning;
                        rowIdx   <= heldRow + 1'b1;
                        settle   <= settleBits'(syncDepth);
                        keyValid <= 1'b0;
                    end
                end
            endcase
        end
    end

    // key code, captured with the hit
    always_ff @(posedge clk) begin
        if ((state == scanning) && hit) begin
            keyCode <= keyMap[hitRow][hitCol];
        end
    end

endmodule

`default_nettype wire

//--- design/keyDebouncer.sv
//////////////////////////////////////////////////////////////////////
// key debouncer
// accepts a key once its code has stayed valid and unchanged for a
// set number of cycles and keeps the last two accepted keys.
// each accepted key moves the right digit to the left digit.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module keyDebouncer
    import keypadPkg::*, displayPkg::*;
#(
    parameter int debounceCycles = 10
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     keyValid,
    input  keyCode_t keyCode,
    output digit_t   leftDigit,
    output digit_t   rightDigit
);

    localparam int cntBits = $clog2(debounceCycles + 1);

    keyCode_t           prevCode;
    logic [cntBits-1:0] stableCount;
    logic               accepted;
    logic               sameKey;

    assign sameKey = keyValid && (keyCode == prevCode);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prevCode    <= '0;
            stableCount <= '0;
            accepted    <= 1'b0;
            leftDigit   <= '0;
            rightDigit  <= '0;
        end else begin
            prevCode <= keyCode;
            if (!keyValid) begin
                // release arms the next press
                stableCount <= '0;
                accepted    <= 1'b0;
            end else if (!sameKey) begin
                stableCount <= '0;
            end else if (!accepted) begin
                if (stableCount == cntBits'(debounceCycles)) begin
                    // stable long enough, shift the history once
                    leftDigit  <= rightDigit;
                    rightDigit <= keyCode;
                    accepted   <= 1'b1;
                end else begin
                    stableCount <= stableCount + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/digitDisplay.sv
//////////////////////////////////////////////////////////////////////
// digit display
// time-multiplexes two hex digits onto one set of active-low
// segment lines, alternating the anodes from a refresh counter
//////////////////////////////////////////////////////////////////////

`default_nettype none

module digitDisplay
    import displayPkg::*;
#(
    parameter int refreshExp = 18
) (
    input  logic      clk,
    input  logic      reset,
    input  digit_t    leftDigit,
    input  digit_t    rightDigit,
    output segments_t seg,
    output logic      anodeLeft,
    output logic      anodeRight
);

    localparam int numPatterns = 2 ** $bits(digit_t);

    // lit segments per hex value, active high, bits g..a
    localparam segments_t segTable [numPatterns] = '{
        7'b0111111,
        7'b0000110,
        7'b1011011,
        7'b1001111,
        7'b1100110,
        7'b1101101,
        7'b1111101,
        7'b0000111,
        7'b1111111,
        7'b1100111,
        7'b1110111,
        7'b1111100,
        7'b1011000,
        7'b1011110,
        7'b1111001,
        7'b1110001
    };

    logic [refreshExp:0] refreshCount;
    digit_t              digits [numDigits];
    digit_t              shownDigit;

    // free-running refresh counter
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            refreshCount <= '0;
        end else begin
            refreshCount <= refreshCount + 1'b1;
        end
    end

    // top bit picks the digit, each half period lights one side
    assign anodeLeft  = refreshCount[refreshExp];
    assign anodeRight = ~anodeLeft;

    // index 1 is the left digit
    assign digits[0] = rightDigit;
    assign digits[1] = leftDigit;

    assign shownDigit = digits[anodeLeft];

    // segments are active low on the board
    assign seg = ~segTable[shownDigit];

endmodule

`default_nettype wire

//--- design/keypadDisplay.sv
//////////////////////////////////////////////////////////////////////
// keypad display top level
// scans a 4x4 hex keypad and shows the last two accepted keys on a
// two-digit multiplexed seven-segment display
//////////////////////////////////////////////////////////////////////

`default_nettype none

module keypadDisplay
    import keypadPkg::*, displayPkg::*;
#(
    parameter int debounceCycles = 10,
    parameter int refreshExp     = 18
) (
    input  logic      clk,
    input  logic      reset,
    input  colLines_t col,
    output rowLines_t row,
    output segments_t seg,
    output logic      anodeLeft,
    output logic      anodeRight
);

    logic     keyValid;
    keyCode_t keyCode;
    digit_t   leftDigit;
    digit_t   rightDigit;

    keypadScanner scanner (
        .clk      (clk),
        .reset    (reset),
        .col      (col),
        .row      (row),
        .keyValid (keyValid),
        .keyCode  (keyCode)
    );

    keyDebouncer #(
        .debounceCycles (debounceCycles)
    ) debouncer (
        .clk        (clk),
        .reset      (reset),
        .keyValid   (keyValid),
        .keyCode    (keyCode),
        .leftDigit  (leftDigit),
        .rightDigit (rightDigit)
    );

    digitDisplay #(
        .refreshExp (refreshExp)
    ) display (
        .clk        (clk),
        .reset      (reset),
        .leftDigit  (leftDigit),
        .rightDigit (rightDigit),
        .seg        (seg),
        .anodeLeft  (anodeLeft),
        .anodeRight (anodeRight)
    );

endmodule

`default_nettype wire

//--- bench/keypadModel.sv
//////////////////////////////////////////////////////////////////////
// keypad model
// behavioral 4x4 keypad with a single pressed key. the key's column
// line follows its row line while the key is held down
//////////////////////////////////////////////////////////////////////

`default_nettype none

module keypadModel
    import keypadPkg::*;
(
    input  logic       pressed,
    input  logic [1:0] keyRow,
    input  logic [1:0] keyCol,
    input  rowLines_t  row,
    output colLines_t  col
);

    timeunit 1ns;
    timeprecision 1ns;

    // a closed key shorts its row line onto its column line,
    // all other columns stay low
    always_comb begin
        col = '0;
        if (pressed && row[keyRow]) begin
            col[keyCol] = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- bench/keypadDisplayTb.sv
//////////////////////////////////////////////////////////////////////
// keypad display testbench
// presses keys on a modeled keypad, checks the multiplexed
// seven-segment output against a two-digit model and checks
// the anode refresh timing
//////////////////////////////////////////////////////////////////////

`default_nettype none

module keypadDisplayTb
    import keypadPkg::*, displayPkg::*;
();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int refreshExp     = 4;
    localparam int debounceCycles = 10;
    localparam int phaseCycles    = 2 ** refreshExp;
    localparam int clkHalf        = 50;
    localparam int resetCycles    = 5;
    localparam int idleCycles     = 20;
    // tests take about 2500 cycles
    localparam int timeoutCycles  = 5000;

    // key at each row and column of the pad
    localparam keyCode_t padLayout [4][4] = '{
        '{4'hA, 4'h0, 4'hB, 4'hF},
        '{4'h7, 4'h8, 4'h9, 4'hE},
        '{4'h4, 4'h5, 4'h6, 4'hD},
        '{4'h1, 4'h2, 4'h3, 4'hC}
    };

    logic       clk = 1'b0;
    logic       reset;
    logic       pressed;
    logic [1:0] keyRow;
    logic [1:0] keyCol;
    rowLines_t  row;
    colLines_t  col;
    segments_t  seg;
    logic       anodeLeft;
    logic       anodeRight;

    // expected display contents
    digit_t     modelLeft;
    digit_t     modelRight;
    keyCode_t   keyOrder [16];
    integer     seed;
    int         errorCount = 0;
    int         checkCount = 0;
    int         cycleCount = 0;
    // clock edges seen by the refresh counter since reset
    int         refreshTicks = 0;
    logic       expectLeft;

    keypadDisplay #(
        .debounceCycles (debounceCycles),
        .refreshExp     (refreshExp)
    ) dut (
        .clk        (clk),
        .reset      (reset),
        .col        (col),
        .row        (row),
        .seg        (seg),
        .anodeLeft  (anodeLeft),
        .anodeRight (anodeRight)
    );

    keypadModel keypad (
        .pressed (pressed),
        .keyRow  (keyRow),
        .keyCol  (keyCol),
        .row     (row),
        .col     (col)
    );

    always #clkHalf clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (!reset) begin
            refreshTicks++;
        end
        if (cycleCount >= timeoutCycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeoutCycles);
            $display("Checks failed");
            $finish;
        end
    end

    // left anode is lit in every odd phase of the refresh count
    always @(negedge clk) begin
        expectLeft = ((refreshTicks / phaseCycles) % 2) == 1;
        checkCount++;
        if (anodeLeft !== expectLeft) begin
            $display("ERROR at %0t ns: anodeLeft expected %b, got %b",
                     $time, expectLeft, anodeLeft);
            errorCount++;
        end
        if (anodeRight !== !expectLeft) begin
            $display("ERROR at %0t ns: anodeRight expected %b, got %b",
                     $time, !expectLeft, anodeRight);
            errorCount++;
        end
        // only one row driven at a time
        if (!$onehot(row)) begin
            $display("ERROR at %0t ns: row expected one-hot, got %b", $time, row);
            errorCount++;
        end
    end

    // lit segments for a hex digit, active high, bits g..a
    function automatic segments_t litSegments(input digit_t value);
        segments_t lit;
        lit = '0;
        case (value)
            4'h0: lit = 7'b0111111;
            4'h1: lit = 7'b0000110;
            4'h2: lit = 7'b1011011;
            4'h3: lit = 7'b1001111;
            4'h4: lit = 7'b1100110;
            4'h5: lit = 7'b1101101;
            4'h6: lit = 7'b1111101;
            4'h7: lit = 7'b0000111;
            4'h8: lit = 7'b1111111;
            4'h9: lit = 7'b1100111;
            4'hA: lit = 7'b1110111;
            4'hB: lit = 7'b1111100;
            4'hC: lit = 7'b1011000;
            4'hD: lit = 7'b1011110;
            4'hE: lit = 7'b1111001;
            4'hF: lit = 7'b1110001;
        endcase
        return lit;
    endfunction

    task automatic locateKey(input keyCode_t key, output logic [1:0] r, output logic [1:0] c);
        r = '0;
        c = '0;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                if (padLayout[i][j] == key) begin
                    r = 2'(i);
                    c = 2'(j);
                end
            end
        end
    endtask

    task automatic compareSeg(input digit_t value, input string side);
        segments_t expected;
        expected = ~litSegments(value);
        checkCount++;
        if (seg !== expected) begin
            $display("ERROR at %0t ns: seg (%s digit) expected %b, got %b",
                     $time, side, expected, seg);
            errorCount++;
        end
    endtask

    // wait for anodeLeft to reach a level, bounded by two phases
    task automatic waitAnode(input logic level, output bit seen);
        int waited;
        waited = 0;
        @(negedge clk);
        while ((anodeLeft !== level) && (waited < 2 * phaseCycles + 2)) begin
            @(negedge clk);
            waited++;
        end
        seen = (anodeLeft === level);
    endtask

    task automatic checkDisplay(input digit_t left, input digit_t right);
        bit seen;
        waitAnode(1'b1, seen);
        if (seen) begin
            compareSeg(left, "left");
        end else begin
            $display("anodeLeft never went high while the display was checked");
            errorCount++;
        end
        waitAnode(1'b0, seen);
        if (seen) begin
            compareSeg(right, "right");
        end else begin
            $display("anodeLeft never went low while the display was checked");
            errorCount++;
        end
    endtask

    // hold a key, release it and let the scanner settle
    task automatic pressKey(input keyCode_t key, input int holdCycles, input bit counts);
        logic [1:0] r;
        logic [1:0] c;
        locateKey(key, r, c);
        @(negedge clk);
        keyRow  = r;
        keyCol  = c;
        pressed = 1'b1;
        repeat (holdCycles) @(negedge clk);
        pressed = 1'b0;
        repeat (idleCycles) @(negedge clk);
        if (counts) begin
            modelLeft  = modelRight;
            modelRight = key;
        end
    endtask

    task automatic checkRefresh(input int periods);
        logic lastLevel;
        int   gap;
        bit   seen;
        @(negedge clk);
        lastLevel = anodeLeft;
        // line up on a toggle first
        waitAnode(~lastLevel, seen);
        if (!seen) begin
            $display("anodeLeft did not toggle during the refresh check");
            errorCount++;
        end else begin
            for (int p = 0; p < periods; p++) begin
                lastLevel = anodeLeft;
                gap = 1;
                @(negedge clk);
                while ((anodeLeft === lastLevel) && (gap < 4 * phaseCycles)) begin
                    @(negedge clk);
                    gap++;
                end
                checkCount++;
                if (gap != phaseCycles) begin
                    $display("ERROR at %0t ns: anodeLeft toggle interval expected %0d, got %0d",
                             $time, phaseCycles, gap);
                    errorCount++;
                end
            end
        end
    endtask

    task automatic idleAfterReset();
        checkDisplay(4'h0, 4'h0);
    endtask

    task automatic singleKeyPress();
        pressKey(4'h5, 40, 1'b1);
        checkDisplay(modelLeft, modelRight);
    endtask

    task automatic allKeysShuffled();
        keyCode_t swapKey;
        int       j;
        for (int i = 0; i < 16; i++) begin
            keyOrder[i] = keyCode_t'(i);
        end
        for (int i = 15; i > 0; i--) begin
            j = int'($unsigned($random(seed)) % (i + 1));
            swapKey     = keyOrder[i];
            keyOrder[i] = keyOrder[j];
            keyOrder[j] = swapKey;
        end
        for (int i = 0; i < 16; i++) begin
            pressKey(keyOrder[i], 40, 1'b1);
            checkDisplay(modelLeft, modelRight);
        end
    endtask

    // a known key first, so a second shift would show C on the left
    task automatic longHoldOnce();
        pressKey(4'h1, 40, 1'b1);
        pressKey(4'hC, 300, 1'b1);
        checkDisplay(modelLeft, modelRight);
    endtask

    task automatic shortPressIgnored();
        pressKey(4'h7, 4, 1'b0);
        checkDisplay(modelLeft, modelRight);
    endtask

    initial begin
        reset      = 1'b1;
        pressed    = 1'b0;
        keyRow     = '0;
        keyCol     = '0;
        modelLeft  = '0;
        modelRight = '0;
        seed       = 32'h7be5_7e6c;
        repeat (resetCycles) @(negedge clk);
        reset = 1'b0;

        idleAfterReset();
        singleKeyPress();
        allKeysShuffled();
        longHoldOnce();
        shortPressIgnored();
        checkRefresh(6);

        $display("summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- keypadDisplay.f
design/keypadPkg.sv
design/displayPkg.sv
design/keypadScanner.sv
design/keyDebouncer.sv
design/digitDisplay.sv
design/keypadDisplay.sv
bench/keypadModel.sv
bench/keypadDisplayTb.sv

//--- runSim.sh
#!/bin/sh
# compile and run the keypad display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns \
    --top-module keypadDisplayTb -f keypadDisplay.f -o keypadSim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/keypadSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All checks passed"; then
    exit 0
fi
echo "simulation reported failure"
exit 1
